//--- rtl/vo_fixed_pkg.sv
package vo_fixed_pkg;

    // ====================
    // Element format
    // ====================

    // Width of one matrix or vector entry
    localparam int ELEM_BW = 64;

    // Signed fixed point, two's complement
    // Sums wrap modulo 2^ELEM_BW, no saturation anywhere in the datapath
    typedef logic signed [ELEM_BW-1:0] elem_t;

    // Zero entry, used when clearing sums
    localparam elem_t ELEM_ZERO = '0;

endpackage

//--- rtl/vo_normal_eq_pkg.sv
package vo_normal_eq_pkg;

    // ====================
    // System dimensions
    // ====================

    // 6-DOF pose update
    localparam int DOF = 6;

    // Lower triangle of a symmetric DOF x DOF matrix
    localparam int N_MAT_ENTRIES = DOF * (DOF + 1) / 2;

    // ====================
    // System layout
    // ====================

    // mat[0] is entry 00, then 10,20,30,40,50,11,21,... up to 55 at mat[20]
    typedef struct packed {
        vo_fixed_pkg::elem_t [N_MAT_ENTRIES-1:0] mat;
        vo_fixed_pkg::elem_t [DOF-1:0]           vec;
    } normal_eq_t;

    // Entry-wise sum of two systems, each entry wraps on its own
    function automatic normal_eq_t add_normal_eq(
        input normal_eq_t a,
        input normal_eq_t b
    );
        normal_eq_t r;
        for (int i = 0; i < N_MAT_ENTRIES; i++) begin
            r.mat[i] = a.mat[i] + b.mat[i];
        end
        for (int j = 0; j < DOF; j++) begin
            r.vec[j] = a.vec[j] + b.vec[j];
        end
        return r;
    endfunction

endpackage

//--- rtl/normal_eq_if.sv
`timescale 1ns/10ps

interface normal_eq_if;
    import vo_normal_eq_pkg::*;

    // Source sum complete, held until taken
    logic       valid;
    // Merger takes the sum at this edge
    logic       ready;
    // Summed system of one source
    normal_eq_t sum;
    // Number of contributions in sum
    logic [7:0] count;

    // Accumulator side
    modport src (
        output valid,
        output sum,
        output count,
        input  ready
    );

    // Merger side
    modport dst (
        input  valid,
        input  sum,
        input  count,
        output ready
    );

endinterface

//--- rtl/normal_eq_accumulator.sv
`timescale 1ns/10ps

module normal_eq_accumulator (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_frame_start,
    input  logic                    i_frame_end,
    input  vo_normal_eq_pkg::normal_eq_t i_contrib,
    normal_eq_if.src                o_sum
);
    import vo_normal_eq_pkg::*;

    // ====================
    // State
    // ====================
    normal_eq_t sum_q;
    logic [7:0] count_q;
    logic       valid_q;
    logic       xfer;

    // Sum leaves this cycle
    assign xfer = valid_q && o_sum.ready;

    // ====================
    // Running sum
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sum_q   <= '0;
            count_q <= '0;
            valid_q <= 1'b0;
        end else if (i_frame_start) begin
            // Frame start wins over a frame end in the same cycle
            sum_q   <= '0;
            count_q <= '0;
            valid_q <= 1'b0;
        end else if (xfer) begin
            if (i_frame_end) begin
                // New sum starts with this payload only
                sum_q   <= i_contrib;
                count_q <= 8'd1;
                valid_q <= 1'b1;
            end else begin
                sum_q   <= '0;
                count_q <= '0;
                valid_q <= 1'b0;
            end
        end else if (i_frame_end) begin
            // Also taken while waiting on the other source
            sum_q   <= add_normal_eq(sum_q, i_contrib);
            count_q <= count_q + 8'd1;
            valid_q <= 1'b1;
        end
    end

    // ====================
    // Outputs
    // ====================
    assign o_sum.valid = valid_q;
    assign o_sum.sum   = sum_q;
    assign o_sum.count = count_q;

endmodule

//--- rtl/normal_eq_merger.sv
`timescale 1ns/10ps

module normal_eq_merger (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_frame_start,
    normal_eq_if.dst                     i_icp,
    normal_eq_if.dst                     i_rgbd,
    output logic                         o_frame_end,
    output vo_normal_eq_pkg::normal_eq_t o_system
);
    import vo_normal_eq_pkg::*;

    // ====================
    // Handshake
    // ====================
    logic       merge;
    normal_eq_t merged;

    // Both sources done, order does not matter
    assign merge = i_icp.valid && i_rgbd.valid && !i_frame_start;

    assign i_icp.ready  = merge;
    assign i_rgbd.ready = merge;

    assign merged = add_normal_eq(i_icp.sum, i_rgbd.sum);

    // ====================
    // Merged system
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_system <= '0;
        end else if (i_frame_start) begin
            o_system <= '0;
        end else if (merge) begin
            o_system <= merged;
        end
    end

    // One-cycle pulse after each merge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_frame_end <= 1'b0;
        end else begin
            o_frame_end <= merge;
        end
    end

endmodule

//--- rtl/normal_eq_combine.sv
`timescale 1ns/10ps

module normal_eq_combine (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_frame_start,
    // ICP source
    input  logic                i_icp_frame_end,
    input  vo_fixed_pkg::elem_t i_icp_mat [vo_normal_eq_pkg::N_MAT_ENTRIES],
    input  vo_fixed_pkg::elem_t i_icp_vec [vo_normal_eq_pkg::DOF],
    // RGB-D source
    input  logic                i_rgbd_frame_end,
    input  vo_fixed_pkg::elem_t i_rgbd_mat [vo_normal_eq_pkg::N_MAT_ENTRIES],
    input  vo_fixed_pkg::elem_t i_rgbd_vec [vo_normal_eq_pkg::DOF],
    // Merged system
    output logic                o_frame_end,
    output vo_fixed_pkg::elem_t o_mat [vo_normal_eq_pkg::N_MAT_ENTRIES],
    output vo_fixed_pkg::elem_t o_vec [vo_normal_eq_pkg::DOF]
);
    import vo_normal_eq_pkg::*;

    normal_eq_t icp_contrib;
    normal_eq_t rgbd_contrib;
    normal_eq_t merged;

    normal_eq_if icp_if ();
    normal_eq_if rgbd_if ();

    // ====================
    // Port packing
    // ====================
    always_comb begin
        for (int i = 0; i < N_MAT_ENTRIES; i++) begin
            icp_contrib.mat[i]  = i_icp_mat[i];
            rgbd_contrib.mat[i] = i_rgbd_mat[i];
        end
        for (int j = 0; j < DOF; j++) begin
            icp_contrib.vec[j]  = i_icp_vec[j];
            rgbd_contrib.vec[j] = i_rgbd_vec[j];
        end
    end

    // Unpack merged system, same entry order as the inputs
    always_comb begin
        for (int i = 0; i < N_MAT_ENTRIES; i++) begin
            o_mat[i] = merged.mat[i];
        end
        for (int j = 0; j < DOF; j++) begin
            o_vec[j] = merged.vec[j];
        end
    end

    // ====================
    // Source accumulators
    // ====================
    normal_eq_accumulator u_icp_acc (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (i_frame_start),
        .i_frame_end   (i_icp_frame_end),
        .i_contrib     (icp_contrib),
        .o_sum         (icp_if.src)
    );

    normal_eq_accumulator u_rgbd_acc (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (i_frame_start),
        .i_frame_end   (i_rgbd_frame_end),
        .i_contrib     (rgbd_contrib),
        .o_sum         (rgbd_if.src)
    );

    // ====================
    // Merge
    // ====================
    normal_eq_merger u_merger (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (i_frame_start),
        .i_icp         (icp_if.dst),
        .i_rgbd        (rgbd_if.dst),
        .o_frame_end   (o_frame_end),
        .o_system      (merged)
    );

endmodule

//--- sim/normal_eq_checker.sv
`timescale 1ns/10ps

module normal_eq_checker (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_frame_start,
    input  logic                i_icp_frame_end,
    input  logic                i_rgbd_frame_end,
    input  logic                i_frame_end,
    input  vo_fixed_pkg::elem_t i_mat [vo_normal_eq_pkg::N_MAT_ENTRIES],
    input  vo_fixed_pkg::elem_t i_vec [vo_normal_eq_pkg::DOF]
);
    import vo_fixed_pkg::*;
    import vo_normal_eq_pkg::*;

    // Expected merged systems, oldest first
    normal_eq_t exp_q [$];
    string      name_q [$];
    string      cur_test = "none";

    int   n_pulses     = 0;
    int   n_mismatch   = 0;
    int   n_other      = 0;
    int   cyc          = 0;
    int   last_end_cyc = -1;
    logic clear_pending = 1'b0;

    task automatic set_test(input string name);
        cur_test = name;
    endtask

    task automatic push_expected(input normal_eq_t sys);
        exp_q.push_back(sys);
        name_q.push_back(cur_test);
    endtask

    task automatic check_entry(input string name, input string kind, input int idx,
                               input elem_t exp, input elem_t act);
        if (act !== exp) begin
            n_mismatch++;
            $display("mismatch %s %s[%0d] expected %h actual %h", name, kind, idx, exp, act);
        end
    endtask

    task automatic final_check();
        if (exp_q.size() != 0) begin
            n_other++;
            $display("error: %0d expected merges never showed up at the output", exp_q.size());
        end
    endtask

    // ====================
    // Output watch
    // ====================
    always @(negedge i_clk) begin : compare
        normal_eq_t exp_sys;
        string      name;
        if (i_rst_n) begin
            cyc++;
            // Outputs read zero one cycle after a frame start
            if (clear_pending) begin
                for (int i = 0; i < N_MAT_ENTRIES; i++) begin
                    check_entry(cur_test, "mat", i, '0, i_mat[i]);
                end
                for (int j = 0; j < DOF; j++) begin
                    check_entry(cur_test, "vec", j, '0, i_vec[j]);
                end
            end
            clear_pending = i_frame_start;
            if (i_frame_end) begin
                n_pulses++;
                if (cyc - last_end_cyc != 2) begin
                    n_other++;
                    $display("error: merged output came %0d cycles after the last frame end, not 2",
                             cyc - last_end_cyc);
                end
                if (exp_q.size() == 0) begin
                    n_other++;
                    $display("error: merged output pulse while no merge was expected");
                end else begin
                    exp_sys = exp_q.pop_front();
                    name    = name_q.pop_front();
                    for (int i = 0; i < N_MAT_ENTRIES; i++) begin
                        check_entry(name, "mat", i, exp_sys.mat[i], i_mat[i]);
                    end
                    for (int j = 0; j < DOF; j++) begin
                        check_entry(name, "vec", j, exp_sys.vec[j], i_vec[j]);
                    end
                end
            end
            if (i_icp_frame_end || i_rgbd_frame_end) begin
                last_end_cyc = cyc;
            end
        end
    end

endmodule

//--- sim/normal_eq_combine_tb.sv
`timescale 1ns/10ps

module normal_eq_combine_tb;
    import vo_fixed_pkg::*;
    import vo_normal_eq_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int N_RANDOM       = 50;
    // Seven directed merges ahead of the random frames
    localparam int N_FRAMES       = 7 + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_FRAMES * 40 + 200;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_frame_start;
    logic  i_icp_frame_end;
    elem_t i_icp_mat [N_MAT_ENTRIES];
    elem_t i_icp_vec [DOF];
    logic  i_rgbd_frame_end;
    elem_t i_rgbd_mat [N_MAT_ENTRIES];
    elem_t i_rgbd_vec [DOF];
    logic  o_frame_end;
    elem_t o_mat [N_MAT_ENTRIES];
    elem_t o_vec [DOF];

    // Contributions since the last merge or frame start
    normal_eq_t icp_list [$];
    normal_eq_t rgbd_list [$];

    normal_eq_combine dut (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_frame_start    (i_frame_start),
        .i_icp_frame_end  (i_icp_frame_end),
        .i_icp_mat        (i_icp_mat),
        .i_icp_vec        (i_icp_vec),
        .i_rgbd_frame_end (i_rgbd_frame_end),
        .i_rgbd_mat       (i_rgbd_mat),
        .i_rgbd_vec       (i_rgbd_vec),
        .o_frame_end      (o_frame_end),
        .o_mat            (o_mat),
        .o_vec            (o_vec)
    );

    normal_eq_checker u_checker (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_frame_start    (i_frame_start),
        .i_icp_frame_end  (i_icp_frame_end),
        .i_rgbd_frame_end (i_rgbd_frame_end),
        .i_frame_end      (o_frame_end),
        .i_mat            (o_mat),
        .i_vec            (o_vec)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ====================
    // Reference model
    // ====================
    function automatic normal_eq_t ref_merge(input normal_eq_t icp_q [$],
                                             input normal_eq_t rgbd_q [$]);
        normal_eq_t r;
        r = '0;
        foreach (icp_q[n]) begin
            for (int i = 0; i < N_MAT_ENTRIES; i++) r.mat[i] = r.mat[i] + icp_q[n].mat[i];
            for (int j = 0; j < DOF; j++) r.vec[j] = r.vec[j] + icp_q[n].vec[j];
        end
        foreach (rgbd_q[n]) begin
            for (int i = 0; i < N_MAT_ENTRIES; i++) r.mat[i] = r.mat[i] + rgbd_q[n].mat[i];
            for (int j = 0; j < DOF; j++) r.vec[j] = r.vec[j] + rgbd_q[n].vec[j];
        end
        return r;
    endfunction

    function automatic normal_eq_t random_system(input logic near_wrap);
        normal_eq_t s;
        for (int i = 0; i < N_MAT_ENTRIES; i++) begin
            s.mat[i] = near_wrap ? {32'h7FFF_FFFF, $urandom} : {$urandom, $urandom};
        end
        for (int j = 0; j < DOF; j++) begin
            s.vec[j] = near_wrap ? {32'h7FFF_FFFF, $urandom} : {$urandom, $urandom};
        end
        return s;
    endfunction

    // ====================
    // Stimulus tasks
    // ====================
    task automatic drive_ends(input logic icp_end, input logic rgbd_end, input logic near_wrap);
        normal_eq_t icp_sys;
        normal_eq_t rgbd_sys;
        icp_sys  = random_system(near_wrap);
        rgbd_sys = random_system(near_wrap);
        @(posedge i_clk);
        i_frame_start    <= 1'b0;
        i_icp_frame_end  <= icp_end;
        i_rgbd_frame_end <= rgbd_end;
        for (int i = 0; i < N_MAT_ENTRIES; i++) begin
            i_icp_mat[i]  <= icp_sys.mat[i];
            i_rgbd_mat[i] <= rgbd_sys.mat[i];
        end
        for (int j = 0; j < DOF; j++) begin
            i_icp_vec[j]  <= icp_sys.vec[j];
            i_rgbd_vec[j] <= rgbd_sys.vec[j];
        end
        if (icp_end) icp_list.push_back(icp_sys);
        if (rgbd_end) rgbd_list.push_back(rgbd_sys);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge i_clk);
            i_frame_start    <= 1'b0;
            i_icp_frame_end  <= 1'b0;
            i_rgbd_frame_end <= 1'b0;
        end
    endtask

    task automatic pulse_frame_start();
        @(posedge i_clk);
        i_frame_start    <= 1'b1;
        i_icp_frame_end  <= 1'b0;
        i_rgbd_frame_end <= 1'b0;
        icp_list.delete();
        rgbd_list.delete();
        idle(1);
    endtask

    task automatic start_test(input string name);
        u_checker.set_test(name);
        icp_list.delete();
        rgbd_list.delete();
    endtask

    // Queue the expected system, then wait for the merge pulse
    task automatic expect_merge();
        u_checker.push_expected(ref_merge(icp_list, rgbd_list));
        icp_list.delete();
        rgbd_list.delete();
        do begin
            idle(1);
            @(negedge i_clk);
        end while (!o_frame_end);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin : stimulus
        int   n_first;
        int   first_icp;
        int   same_cycle;
        logic both;
        void'($urandom(32'h7332));
        i_clk            = 1'b0;
        i_rst_n          = 1'b0;
        i_frame_start    = 1'b0;
        i_icp_frame_end  = 1'b0;
        i_rgbd_frame_end = 1'b0;
        for (int i = 0; i < N_MAT_ENTRIES; i++) begin
            i_icp_mat[i]  = '0;
            i_rgbd_mat[i] = '0;
        end
        for (int j = 0; j < DOF; j++) begin
            i_icp_vec[j]  = '0;
            i_rgbd_vec[j] = '0;
        end
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        idle(2);

        start_test("icp_then_rgbd");
        drive_ends(1'b1, 1'b0, 1'b0);
        idle(4);
        drive_ends(1'b0, 1'b1, 1'b0);
        expect_merge();

        start_test("rgbd_then_icp");
        drive_ends(1'b0, 1'b1, 1'b0);
        idle(5);
        drive_ends(1'b1, 1'b0, 1'b0);
        expect_merge();

        start_test("same_cycle_ends");
        drive_ends(1'b1, 1'b1, 1'b0);
        expect_merge();

        // The first source keeps adding while the other is missing
        start_test("multi_icp_wrap");
        drive_ends(1'b1, 1'b0, 1'b1);
        idle(1);
        drive_ends(1'b1, 1'b0, 1'b1);
        drive_ends(1'b1, 1'b0, 1'b1);
        idle(2);
        drive_ends(1'b0, 1'b1, 1'b1);
        expect_merge();
        start_test("multi_rgbd_wrap");
        drive_ends(1'b0, 1'b1, 1'b1);
        idle(2);
        drive_ends(1'b0, 1'b1, 1'b1);
        drive_ends(1'b1, 1'b0, 1'b1);
        expect_merge();

        start_test("clear_after_merge");
        drive_ends(1'b1, 1'b0, 1'b0);
        drive_ends(1'b0, 1'b1, 1'b0);
        expect_merge();
        pulse_frame_start();
        idle(2);
        start_test("discard_partial");
        drive_ends(1'b1, 1'b0, 1'b0);
        idle(2);
        pulse_frame_start();
        drive_ends(1'b1, 1'b0, 1'b0);
        idle(2);
        drive_ends(1'b0, 1'b1, 1'b0);
        expect_merge();

        for (int f = 0; f < N_RANDOM; f++) begin
            start_test($sformatf("random_%0d", f));
            pulse_frame_start();
            idle($urandom_range(0, 2));
            first_icp  = $urandom_range(0, 1);
            n_first    = $urandom_range(1, 3);
            same_cycle = $urandom_range(0, 1);
            for (int k = 0; k < n_first; k++) begin
                both = (k == n_first - 1) && (same_cycle != 0);
                if (first_icp != 0) drive_ends(1'b1, both, 1'b0);
                else drive_ends(both, 1'b1, 1'b0);
                if (k != n_first - 1) idle($urandom_range(0, 3));
            end
            if (same_cycle == 0) begin
                idle($urandom_range(0, 3));
                drive_ends(first_icp == 0, first_icp != 0, 1'b0);
            end
            expect_merge();
        end

        idle(4);
        u_checker.final_check();
        $display("errors: %0d mismatches, %0d other failures, %0d merges seen",
                 u_checker.n_mismatch, u_checker.n_other, u_checker.n_pulses);
        if (u_checker.n_mismatch + u_checker.n_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("error: timeout after %0d cycles, the test sequence did not finish",
                 TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- normal_eq_combine.f
rtl/vo_fixed_pkg.sv
rtl/vo_normal_eq_pkg.sv
rtl/normal_eq_if.sv
rtl/normal_eq_accumulator.sv
rtl/normal_eq_merger.sv
rtl/normal_eq_combine.sv
sim/normal_eq_checker.sv
sim/normal_eq_combine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the normal_eq_combine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module normal_eq_combine_tb \
    -f normal_eq_combine.f

out=$(./obj_dir/Vnormal_eq_combine_tb)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
